// File: source/soc_pkg.sv
`default_nettype none

package soc_pkg;

    localparam int ram_addr_bits = 8;
    localparam int ram_words = 256;
    localparam int bootrom_addr_bits = 6;
    localparam int bootrom_words = 64;
    localparam int gpio_width = 16;
    localparam int periph_page_bits = 12; // peripherals decode on 4 KB pages

    localparam logic [31:0] bootrom_base = 32'h0000_0000;
    localparam logic [31:0] ram_base = 32'h8000_0000;
    localparam logic [31:0] timer_base = 32'hbfd0_0000; // +0 count, +4 compare
    localparam logic [31:0] gpio_base = 32'hbfd0_1000;  // +0 out, +4 in

    typedef struct packed {
        logic        req;   // held until done
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
    } bus_req_t;

    typedef struct packed {
        logic        done;  // single cycle
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef enum logic [2:0] {
        region_bootrom,
        region_ram,
        region_timer,
        region_gpio,
        region_none
    } region_e;

    // boot stub: set bit 0 of gpio out, then jump to ram
    localparam logic [31:0] bootrom_image [bootrom_words] = '{
        0: 32'h3c08_8000,  // lui   t0, 0x8000
        1: 32'h3508_0000,  // ori   t0, t0, 0
        2: 32'h3c09_bfd0,  // lui   t1, 0xbfd0
        3: 32'h3529_1000,  // ori   t1, t1, 0x1000
        4: 32'h240a_0001,  // addiu t2, zero, 1
        5: 32'had2a_0000,  // sw    t2, 0(t1)
        6: 32'h0100_0008,  // jr    t0
        7: 32'h0000_0000,  // nop
        default: 32'h0000_0000
    };

    function automatic region_e decode_region(input logic [31:0] addr);
        if (addr[31:bootrom_addr_bits+2] == bootrom_base[31:bootrom_addr_bits+2])
            return region_bootrom;
        if (addr[31:ram_addr_bits+2] == ram_base[31:ram_addr_bits+2])
            return region_ram;
        if (addr[31:periph_page_bits] == timer_base[31:periph_page_bits])
            return region_timer;
        if (addr[31:periph_page_bits] == gpio_base[31:periph_page_bits])
            return region_gpio;
        return region_none;
    endfunction

endpackage

`default_nettype wire

// File: source/instruction_bus.sv
`default_nettype none

module instruction_bus (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::bus_req_t inst_req,
    output soc_pkg::bus_rsp_t inst_rsp,
    output soc_pkg::bus_req_t ram_req,
    input  soc_pkg::bus_rsp_t ram_rsp,
    output soc_pkg::bus_req_t rom_req,
    input  soc_pkg::bus_rsp_t rom_rsp
);

    soc_pkg::region_e region;
    logic none_done;

    always_comb begin
        region = soc_pkg::decode_region(inst_req.addr);
        ram_req = inst_req;
        rom_req = inst_req;
        ram_req.req = inst_req.req && region == soc_pkg::region_ram;
        rom_req.req = inst_req.req && region == soc_pkg::region_bootrom;
    end

    // fetches from anywhere else finish here with zero
    always_ff @(posedge clk) begin
        if (!rst_n)
            none_done <= 1'b0;
        else
            none_done <= inst_req.req && !none_done
                         && region != soc_pkg::region_ram
                         && region != soc_pkg::region_bootrom;
    end

    always_comb begin
        inst_rsp.done = ram_rsp.done || rom_rsp.done || none_done;
        if (rom_rsp.done)
            inst_rsp.rdata = rom_rsp.rdata;
        else if (ram_rsp.done)
            inst_rsp.rdata = ram_rsp.rdata;
        else
            inst_rsp.rdata = '0;
    end

endmodule

`default_nettype wire

// File: source/data_bus.sv
`default_nettype none

module data_bus (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::bus_req_t data_req,
    output soc_pkg::bus_rsp_t data_rsp,
    output soc_pkg::bus_req_t rom_req,
    input  soc_pkg::bus_rsp_t rom_rsp,
    output soc_pkg::bus_req_t ram_req,
    input  soc_pkg::bus_rsp_t ram_rsp,
    output soc_pkg::bus_req_t timer_req,
    input  soc_pkg::bus_rsp_t timer_rsp,
    output soc_pkg::bus_req_t gpio_req,
    input  soc_pkg::bus_rsp_t gpio_rsp
);

    soc_pkg::region_e region_q;
    soc_pkg::region_e sel;
    logic active;
    logic none_done;

    // decode only when idle, then stick with the captured target
    assign sel = active ? region_q : soc_pkg::decode_region(data_req.addr);

    always_comb begin
        rom_req = data_req;
        ram_req = data_req;
        timer_req = data_req;
        gpio_req = data_req;
        rom_req.req = data_req.req && sel == soc_pkg::region_bootrom;
        ram_req.req = data_req.req && sel == soc_pkg::region_ram;
        timer_req.req = data_req.req && sel == soc_pkg::region_timer;
        gpio_req.req = data_req.req && sel == soc_pkg::region_gpio;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            region_q <= soc_pkg::region_none;
            none_done <= 1'b0;
        end else begin
            if (data_rsp.done) begin
                active <= 1'b0;
            end else if (data_req.req && !active) begin
                active <= 1'b1;
                region_q <= sel;
            end
            none_done <= data_req.req && sel == soc_pkg::region_none && !none_done;
        end
    end

    always_comb begin
        case (region_q)
            soc_pkg::region_bootrom: data_rsp = rom_rsp;
            soc_pkg::region_ram:     data_rsp = ram_rsp;
            soc_pkg::region_timer:   data_rsp = timer_rsp;
            soc_pkg::region_gpio:    data_rsp = gpio_rsp;
            default: begin
                data_rsp.done = none_done; // unmapped, writes dropped
                data_rsp.rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/ram_controller.sv
`default_nettype none

module ram_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::bus_req_t inst_req,
    output soc_pkg::bus_rsp_t inst_rsp,
    input  soc_pkg::bus_req_t data_req,
    output soc_pkg::bus_rsp_t data_rsp
);

    typedef enum logic {
        ram_idle,
        ram_serve
    } ram_state_e;

    ram_state_e state;
    logic last_data;   // last grant went to the data port
    logic grant_valid;
    logic grant_data;
    soc_pkg::bus_req_t sel_req;
    logic [soc_pkg::ram_addr_bits-1:0] word_idx;
    logic [31:0] rdata_q;
    logic [31:0] mem [soc_pkg::ram_words];

    always_comb begin
        grant_valid = 1'b0;
        grant_data = 1'b0;
        if (state == ram_idle) begin
            if (inst_req.req && data_req.req) begin
                grant_valid = 1'b1;
                grant_data = !last_data; // round robin
            end else if (inst_req.req || data_req.req) begin
                grant_valid = 1'b1;
                grant_data = data_req.req;
            end
        end else begin
            // port being finished is ignored, the other may start
            if (last_data && inst_req.req) begin
                grant_valid = 1'b1;
                grant_data = 1'b0;
            end else if (!last_data && data_req.req) begin
                grant_valid = 1'b1;
                grant_data = 1'b1;
            end
        end
    end

    assign sel_req = grant_data ? data_req : inst_req;
    assign word_idx = sel_req.addr[soc_pkg::ram_addr_bits+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ram_idle;
            last_data <= 1'b0;
        end else begin
            state <= grant_valid ? ram_serve : ram_idle;
            if (grant_valid)
                last_data <= grant_data;
        end
    end

    // single port array, one access per grant
    always_ff @(posedge clk) begin
        if (grant_valid) begin
            rdata_q <= mem[word_idx];
            if (grant_data && sel_req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel_req.be[b])
                        mem[word_idx][8*b +: 8] <= sel_req.wdata[8*b +: 8];
                end
            end
        end
    end

    assign inst_rsp.done = state == ram_serve && !last_data;
    assign inst_rsp.rdata = rdata_q;
    assign data_rsp.done = state == ram_serve && last_data;
    assign data_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// File: source/bootrom_controller.sv
`default_nettype none

module bootrom_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::bus_req_t inst_req,
    output soc_pkg::bus_rsp_t inst_rsp,
    input  soc_pkg::bus_req_t data_req,
    output soc_pkg::bus_rsp_t data_rsp
);

    soc_pkg::bus_req_t port_req [2];
    logic [1:0] done_q;
    logic [31:0] rdata_q [2];

    assign port_req[0] = inst_req;
    assign port_req[1] = data_req;

    // both ports read the image independently, writes just complete
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= '0;
        end else begin
            for (int p = 0; p < 2; p++)
                done_q[p] <= port_req[p].req && !done_q[p];
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (port_req[p].req && !done_q[p])
                rdata_q[p] <= soc_pkg::bootrom_image[
                    port_req[p].addr[soc_pkg::bootrom_addr_bits+1:2]];
        end
    end

    assign inst_rsp.done = done_q[0];
    assign inst_rsp.rdata = rdata_q[0];
    assign data_rsp.done = done_q[1];
    assign data_rsp.rdata = rdata_q[1];

endmodule

`default_nettype wire

// File: source/timer_controller.sv
`default_nettype none

module timer_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::bus_req_t bus_req,
    output soc_pkg::bus_rsp_t bus_rsp,
    output logic              timer_irq
);

    logic [31:0] count;
    logic [31:0] compare;
    logic done_q;
    logic [31:0] rdata_q;
    logic start;

    assign start = bus_req.req && !done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            compare <= '0;
            timer_irq <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= start;
            if (start && bus_req.we && !bus_req.addr[2])
                count <= bus_req.wdata;
            else
                count <= count + 32'd1;
            if (start && bus_req.we && bus_req.addr[2]) begin
                compare <= bus_req.wdata;
                timer_irq <= 1'b0; // compare write acks the irq
            end else if (count == compare && compare != '0) begin
                timer_irq <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            rdata_q <= bus_req.addr[2] ? compare : count;
    end

    assign bus_rsp.done = done_q;
    assign bus_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// File: source/gpio_controller.sv
`default_nettype none

module gpio_controller (
    input  logic                           clk,
    input  logic                           rst_n,
    input  soc_pkg::bus_req_t              bus_req,
    output soc_pkg::bus_rsp_t              bus_rsp,
    input  logic [soc_pkg::gpio_width-1:0] gpio_in,
    output logic [soc_pkg::gpio_width-1:0] gpio_out
);

    logic [soc_pkg::gpio_width-1:0] in_meta;
    logic [soc_pkg::gpio_width-1:0] in_sync;
    logic done_q;
    logic [31:0] rdata_q;
    logic start;

    assign start = bus_req.req && !done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= start;
            if (start && bus_req.we && !bus_req.addr[2]) begin
                if (bus_req.be[0])
                    gpio_out[7:0] <= bus_req.wdata[7:0];
                if (bus_req.be[1])
                    gpio_out[15:8] <= bus_req.wdata[15:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        in_meta <= gpio_in; // two flop sync
        in_sync <= in_meta;
        if (start)
            rdata_q <= {{(32-soc_pkg::gpio_width){1'b0}},
                        bus_req.addr[2] ? in_sync : gpio_out};
    end

    assign bus_rsp.done = done_q;
    assign bus_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// File: source/soc_top.sv
`default_nettype none

module soc_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  soc_pkg::bus_req_t              inst_req,
    output soc_pkg::bus_rsp_t              inst_rsp,
    input  soc_pkg::bus_req_t              data_req,
    output soc_pkg::bus_rsp_t              data_rsp,
    input  logic [soc_pkg::gpio_width-1:0] gpio_in,
    output logic [soc_pkg::gpio_width-1:0] gpio_out,
    output logic                           timer_irq
);

    soc_pkg::bus_req_t ram_inst_req, rom_inst_req;
    soc_pkg::bus_rsp_t ram_inst_rsp, rom_inst_rsp;
    soc_pkg::bus_req_t ram_data_req, rom_data_req, timer_req, gpio_req;
    soc_pkg::bus_rsp_t ram_data_rsp, rom_data_rsp, timer_rsp, gpio_rsp;

    instruction_bus instruction_bus_inst (
        .clk, .rst_n,
        .inst_req, .inst_rsp,
        .ram_req(ram_inst_req), .ram_rsp(ram_inst_rsp),
        .rom_req(rom_inst_req), .rom_rsp(rom_inst_rsp)
    );

    data_bus data_bus_inst (
        .clk, .rst_n,
        .data_req, .data_rsp,
        .rom_req(rom_data_req), .rom_rsp(rom_data_rsp),
        .ram_req(ram_data_req), .ram_rsp(ram_data_rsp),
        .timer_req, .timer_rsp,
        .gpio_req, .gpio_rsp
    );

    // shared by both masters
    ram_controller ram_controller_inst (
        .clk, .rst_n,
        .inst_req(ram_inst_req), .inst_rsp(ram_inst_rsp),
        .data_req(ram_data_req), .data_rsp(ram_data_rsp)
    );

    bootrom_controller bootrom_controller_inst (
        .clk, .rst_n,
        .inst_req(rom_inst_req), .inst_rsp(rom_inst_rsp),
        .data_req(rom_data_req), .data_rsp(rom_data_rsp)
    );

    timer_controller timer_controller_inst (
        .clk, .rst_n,
        .bus_req(timer_req), .bus_rsp(timer_rsp),
        .timer_irq
    );

    gpio_controller gpio_controller_inst (
        .clk, .rst_n,
        .bus_req(gpio_req), .bus_rsp(gpio_rsp),
        .gpio_in, .gpio_out
    );

endmodule

`default_nettype wire

// File: tb/tb_soc_top.sv
`default_nettype none

module tb_soc_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 50;

    logic clk = 1'b0;
    logic rst_n;
    soc_pkg::bus_req_t inst_req;
    soc_pkg::bus_req_t data_req;
    soc_pkg::bus_rsp_t inst_rsp;
    soc_pkg::bus_rsp_t data_rsp;
    logic [soc_pkg::gpio_width-1:0] gpio_in;
    logic [soc_pkg::gpio_width-1:0] gpio_out;
    logic timer_irq;

    logic [31:0] lfsr = 32'hc2cec87e;
    logic [31:0] shadow [soc_pkg::ram_words]; // expected ram contents
    int used_idx [$];
    logic inst_busy = 1'b0;
    logic data_busy = 1'b0;
    logic rr_check = 1'b0;
    int inst_streak;
    int data_streak;

    soc_top soc_top_inst (
        .clk, .rst_n,
        .inst_req, .inst_rsp,
        .data_req, .data_rsp,
        .gpio_in, .gpio_out, .timer_irq
    );

    always #50 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [3:0] be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old & ~mask) | (wdata & mask);
    endfunction

    function automatic logic [31:0] ram_addr(input int idx);
        return soc_pkg::ram_base + 32'(idx) * 32'd4;
    endfunction

    task automatic fail_with(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else fail_with($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    // keep leaves req high so the next fetch follows back to back
    task automatic fetch(input logic [31:0] addr, input bit keep, output logic [31:0] rdata);
        int cycles;
        @(posedge clk);
        inst_req <= '{req: 1'b1, we: 1'b0, addr: addr, wdata: 32'h0, be: 4'hf};
        inst_busy = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles)
                fail_with($sformatf("fetch from 0x%08h never completed", addr));
        end while (!inst_rsp.done);
        rdata = inst_rsp.rdata;
        inst_busy = 1'b0;
        if (!keep) begin
            @(posedge clk);
            inst_req.req <= 1'b0;
        end
    endtask

    task automatic data_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be,
                               output logic [31:0] rdata);
        int cycles;
        @(posedge clk);
        data_req <= '{req: 1'b1, we: we, addr: addr, wdata: wdata, be: be};
        data_busy = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles)
                fail_with($sformatf("data access to 0x%08h never completed", addr));
        end while (!data_rsp.done);
        rdata = data_rsp.rdata;
        data_busy = 1'b0;
        @(posedge clk);
        data_req.req <= 1'b0;
    endtask

    task automatic data_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be);
        logic [31:0] unused;
        data_access(1'b1, addr, wdata, be, unused);
    endtask

    task automatic data_read(input logic [31:0] addr, output logic [31:0] rdata);
        data_access(1'b0, addr, 32'h0, 4'hf, rdata);
    endtask

    // a port may not win twice while the other one waits
    always @(negedge clk) begin
        if (rr_check && inst_rsp.done) begin
            inst_streak = data_busy ? inst_streak + 1 : 0;
            data_streak = 0;
            assert (inst_streak < 2)
            else fail_with("instruction port served twice while the data port waited");
        end
        if (rr_check && data_rsp.done) begin
            data_streak = inst_busy ? data_streak + 1 : 0;
            inst_streak = 0;
            assert (data_streak < 2)
            else fail_with("data port served twice while the instruction port waited");
        end
    end

    initial begin
        logic [31:0] got;
        logic [31:0] got_d;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] count_a;
        logic [31:0] count_b;
        logic [31:0] gpio_exp;
        logic [15:0] pins;
        logic [3:0] be;
        int idx;
        int idx_d;
        int polls;

        rst_n = 1'b0;
        inst_req = '0;
        data_req = '0;
        gpio_in = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("inst_rsp.done", inst_rsp.done, 0);
        check_value("data_rsp.done", data_rsp.done, 0);
        check_value("timer_irq", timer_irq, 0);
        check_value("gpio_out", gpio_out, 0);

        // boot rom on both ports, then both in the same cycle
        for (int i = 0; i < 8; i++) begin
            addr = soc_pkg::bootrom_base + 32'(i * 4);
            fetch(addr, 1'b0, got);
            check_value("inst_rsp.rdata", got, soc_pkg::bootrom_image[i]);
            data_read(addr, got);
            check_value("data_rsp.rdata", got, soc_pkg::bootrom_image[i]);
        end
        for (int i = 0; i < 4; i++) begin
            idx = lfsr_bits(3);
            idx_d = lfsr_bits(3);
            fork
                fetch(soc_pkg::bootrom_base + 32'(idx * 4), 1'b0, got);
                data_read(soc_pkg::bootrom_base + 32'(idx_d * 4), got_d);
            join
            check_value("inst_rsp.rdata", got, soc_pkg::bootrom_image[idx]);
            check_value("data_rsp.rdata", got_d, soc_pkg::bootrom_image[idx_d]);
        end

        // ram writes with byte enables
        for (int i = 0; i < 8; i++) begin
            idx = lfsr_bits(soc_pkg::ram_addr_bits);
            wdata = lfsr_bits(32);
            data_write(ram_addr(idx), wdata, 4'hf);
            shadow[idx] = wdata;
            wdata = lfsr_bits(32);
            be = lfsr_bits(4);
            data_write(ram_addr(idx), wdata, be);
            shadow[idx] = merge_bytes(shadow[idx], wdata, be);
            data_read(ram_addr(idx), got);
            check_value("data_rsp.rdata", got, shadow[idx]);
            fetch(ram_addr(idx), 1'b0, got);
            check_value("inst_rsp.rdata", got, shadow[idx]);
            used_idx.push_back(idx);
        end

        // both masters on the ram at once
        inst_streak = 0;
        data_streak = 0;
        rr_check = 1'b1;
        fork
            for (int j = 0; j < 8; j++) begin
                fetch(ram_addr(used_idx[j]), j < 7, got);
                check_value("inst_rsp.rdata", got, shadow[used_idx[j]]);
            end
            for (int j = 0; j < 4; j++) begin
                data_read(ram_addr(used_idx[7 - j]), got_d);
                check_value("data_rsp.rdata", got_d, shadow[used_idx[7 - j]]);
            end
        join
        rr_check = 1'b0;

        // gpio out register and input sync
        gpio_exp = '0;
        for (int i = 0; i < 3; i++) begin
            wdata = lfsr_bits(32);
            be = lfsr_bits(4);
            data_write(soc_pkg::gpio_base, wdata, be);
            gpio_exp = merge_bytes(gpio_exp, wdata, {2'b00, be[1:0]});
            @(negedge clk);
            check_value("gpio_out", gpio_out, gpio_exp);
            data_read(soc_pkg::gpio_base, got);
            check_value("data_rsp.rdata", got, gpio_exp);
            pins = lfsr_bits(16);
            @(posedge clk);
            gpio_in <= pins;
            polls = 0;
            do begin
                polls++;
                if (polls > 10)
                    fail_with("gpio_in value never reached the input register");
                data_read(soc_pkg::gpio_base + 32'h4, got);
            end while (got != {16'h0, pins});
        end

        // timer count, compare and irq
        data_read(soc_pkg::timer_base, count_a);
        data_read(soc_pkg::timer_base, count_b);
        assert (count_b > count_a)
        else fail_with($sformatf("FAILED data_rsp.rdata: count 0x%08h after 0x%08h",
                                 count_b, count_a));
        data_write(soc_pkg::timer_base + 32'h4, count_b + 32'd20, 4'hf);
        @(negedge clk);
        check_value("timer_irq", timer_irq, 0);
        polls = 0;
        while (!timer_irq) begin
            @(negedge clk);
            polls++;
            if (polls > timeout_cycles)
                fail_with("timer_irq never rose after the compare write");
        end
        data_read(soc_pkg::timer_base + 32'h4, got);
        check_value("data_rsp.rdata", got, count_b + 32'd20);
        data_write(soc_pkg::timer_base + 32'h4, 32'h0, 4'hf);
        @(negedge clk);
        check_value("timer_irq", timer_irq, 0);

        // unmapped accesses, low bits alias ram words
        fetch(32'h4000_0000, 1'b0, got);
        check_value("inst_rsp.rdata", got, 0);
        fetch(soc_pkg::timer_base, 1'b0, got); // not fetchable
        check_value("inst_rsp.rdata", got, 0);
        data_read(32'h4000_0010, got);
        check_value("data_rsp.rdata", got, 0);
        for (int i = 0; i < 4; i++)
            data_write(32'h4000_0000 | 32'(used_idx[i] * 4), lfsr_bits(32), 4'hf);
        foreach (used_idx[i]) begin
            data_read(ram_addr(used_idx[i]), got);
            check_value("data_rsp.rdata", got, shadow[used_idx[i]]);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
source/soc_pkg.sv
source/instruction_bus.sv
source/data_bus.sv
source/ram_controller.sv
source/bootrom_controller.sv
source/timer_controller.sv
source/gpio_controller.sv
source/soc_top.sv
tb/tb_soc_top.sv

// File: Bender.yml
package:
  name: soc_skeleton

sources:
  - files:
      - source/soc_pkg.sv
      - source/instruction_bus.sv
      - source/data_bus.sv
      - source/ram_controller.sv
      - source/bootrom_controller.sv
      - source/timer_controller.sv
      - source/gpio_controller.sv
      - source/soc_top.sv
  - target: test
    files:
      - tb/tb_soc_top.sv
